/* compile.f */
mhq_pkg.sv
mhq_lookup.sv
mhq_execute.sv
mhq_fill.sv
mhq.sv
mhq_asserts.sv
mhq_tb.sv

/* mhq.sv */
// MHQ top level: lookup, execute and fill stages with the fill record split onto ports
`timescale 1ns/100ps

module mhq
    import mhq_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,

    // LSU lookup of a cache miss
    input  logic              i_lookup_valid,
    input  logic              i_lookup_dc_hit,
    input  logic [ADDR_W-1:0] i_lookup_addr,
    input  lsu_func_t         i_lookup_func,
    input  logic [DATA_W-1:0] i_lookup_data,
    output mhq_tag_t          o_lookup_tag,
    output logic              o_lookup_full,

    // Line fill towards the data cache
    output logic              o_fill_en,
    output mhq_tag_t          o_fill_tag,
    output logic              o_fill_dirty,
    output logic [ADDR_W-1:0] o_fill_addr,
    output cacheline_t        o_fill_data,

    // CCU line request
    input  logic              i_ccu_done,
    input  cacheline_t        i_ccu_data,
    output logic              o_ccu_en,
    output logic [ADDR_W-1:0] o_ccu_addr
);

    mhq_entry_t [MHQ_DEPTH-1:0] entries;
    mhq_tag_t                   tail;
    mhq_tag_t                   head;
    logic                       full;
    mhq_lu_t                    lu;
    mhq_lu_t                    bypass;
    logic                       retire;
    logic                       dequeue;
    mhq_fill_t                  fill;

    mhq_lookup u_lookup (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_lookup_valid  (i_lookup_valid),
        .i_lookup_dc_hit (i_lookup_dc_hit),
        .i_lookup_addr   (i_lookup_addr),
        .i_lookup_func   (i_lookup_func),
        .i_lookup_data   (i_lookup_data),
        .i_entries       (entries),
        .i_tail          (tail),
        .i_full          (full),
        .i_bypass        (bypass),
        .o_lu            (lu)
    );

    mhq_execute u_execute (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_lu      (lu),
        .i_retire  (retire),
        .i_dequeue (dequeue),
        .o_entries (entries),
        .o_tail    (tail),
        .o_head    (head),
        .o_full    (full),
        .o_bypass  (bypass)
    );

    mhq_fill u_fill (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_head_entry (entries[head]),
        .i_head       (head),
        .i_ccu_done   (i_ccu_done),
        .i_ccu_data   (i_ccu_data),
        .o_ccu_en     (o_ccu_en),
        .o_ccu_addr   (o_ccu_addr),
        .o_retire     (retire),
        .o_dequeue    (dequeue),
        .o_fill_en    (o_fill_en),
        .o_fill       (fill)
    );

    assign o_lookup_tag  = lu.tag;
    assign o_lookup_full = full;

    assign o_fill_tag    = fill.tag;
    assign o_fill_dirty  = fill.dirty;
    assign o_fill_addr   = {fill.addr, {OFFSET_W{1'b0}}};
    assign o_fill_data   = fill.data;

endmodule

/* mhq_asserts.sv */
// Concurrent checks on the MHQ fill strobe, the CCU request level and the CCU request address
`timescale 1ns/100ps

module mhq_asserts
    import mhq_pkg::*;
(
    input logic              clk,
    input logic              i_reset,
    input logic              i_fill_en,
    input logic              i_ccu_en,
    input logic              i_ccu_done,
    input logic [ADDR_W-1:0] i_ccu_addr
);

    // A fill is a single-cycle strobe
    fill_en_single: assert property (@(posedge clk) disable iff (i_reset)
        i_fill_en |=> !i_fill_en)
        else $error("o_fill_en stayed high for two cycles");

    // The CCU request is a level held until the CCU answers
    ccu_en_held: assert property (@(posedge clk) disable iff (i_reset)
        (i_ccu_en && !i_ccu_done) |=> i_ccu_en)
        else $error("o_ccu_en dropped before i_ccu_done");

    // The requested line does not change while the CCU is still working on it
    ccu_addr_stable: assert property (@(posedge clk) disable iff (i_reset)
        (i_ccu_en && !i_ccu_done) |=> $stable(i_ccu_addr))
        else $error("o_ccu_addr changed while the CCU request was outstanding");

endmodule

bind mhq mhq_asserts u_asserts (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_fill_en  (o_fill_en),
    .i_ccu_en   (o_ccu_en),
    .i_ccu_done (i_ccu_done),
    .i_ccu_addr (o_ccu_addr)
);

/* mhq_execute.sv */
// MHQ execute stage: entry array, head and tail pointers, count, allocation, store merge and free
`timescale 1ns/100ps

module mhq_execute
    import mhq_pkg::*;
(
    input  logic                       clk,
    input  logic                       i_reset,

    input  mhq_lu_t                    i_lu,
    input  logic                       i_retire,
    input  logic                       i_dequeue,

    output mhq_entry_t [MHQ_DEPTH-1:0] o_entries,
    output mhq_tag_t                   o_tail,
    output mhq_tag_t                   o_head,
    output logic                       o_full,
    output mhq_lu_t                    o_bypass
);

    mhq_entry_t [MHQ_DEPTH-1:0] entries_q;
    mhq_tag_t                   head_q;
    mhq_tag_t                   tail_q;
    logic [MHQ_TAG_W:0]         count_q;
    logic                       alloc;
    logic                       merge;

    assign alloc = i_lu.en && !i_lu.match;
    assign merge = i_lu.en && i_lu.match && i_lu.we;

    always_ff @(posedge clk) begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (i_reset) begin
                entries_q[i].valid    <= 1'b0;
                entries_q[i].retiring <= 1'b0;
                entries_q[i].dirty    <= 1'b0;
            end else begin
                if (alloc && (tail_q == mhq_tag_t'(i))) begin
                    entries_q[i].valid     <= 1'b1;
                    entries_q[i].retiring  <= 1'b0;
                    entries_q[i].dirty     <= i_lu.we;
                    entries_q[i].addr      <= i_lu.addr;
                    entries_q[i].data      <= i_lu.data;
                    entries_q[i].byte_mask <= i_lu.byte_mask;
                end else if (merge && (i_lu.tag == mhq_tag_t'(i))) begin
                    entries_q[i].dirty     <= 1'b1;
                    entries_q[i].byte_mask <= entries_q[i].byte_mask | i_lu.byte_mask;
                    for (int b = 0; b < LINE_BYTES; b++) begin
                        if (i_lu.byte_mask[b]) begin
                            entries_q[i].data[b*8 +: 8] <= i_lu.data[b*8 +: 8];
                        end
                    end
                end

                if (i_retire && (head_q == mhq_tag_t'(i))) begin
                    entries_q[i].retiring <= 1'b1;
                end

                if (i_dequeue && (head_q == mhq_tag_t'(i))) begin
                    entries_q[i].valid    <= 1'b0;
                    entries_q[i].retiring <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc) begin
                tail_q <= tail_q + 1'b1;
            end
            if (i_dequeue) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc, i_dequeue})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Lookup sees the head as retiring already in the cycle of the retire strobe,
    // so a lookup in that cycle cannot merge into a line whose fill is being built
    always_comb begin
        o_entries = entries_q;
        if (i_retire) begin
            o_entries[head_q].retiring = 1'b1;
        end
    end

    assign o_head   = head_q;
    assign o_tail   = tail_q;
    assign o_full   = (count_q == (MHQ_TAG_W+1)'(MHQ_DEPTH));
    assign o_bypass = i_lu;

endmodule

/* mhq_fill.sv */
// MHQ fill stage: CCU request FSM for the head entry and the merged, dirty-flagged line fill
`timescale 1ns/100ps

module mhq_fill
    import mhq_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,

    input  mhq_entry_t        i_head_entry,
    input  mhq_tag_t          i_head,

    input  logic              i_ccu_done,
    input  cacheline_t        i_ccu_data,
    output logic              o_ccu_en,
    output logic [ADDR_W-1:0] o_ccu_addr,

    output logic              o_retire,
    output logic              o_dequeue,
    output logic              o_fill_en,
    output mhq_fill_t         o_fill
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_FILL
    } fill_state_t;

    fill_state_t state_q;
    cacheline_t  ccu_data_q;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:    if (i_head_entry.valid) state_q <= ST_REQUEST;
                ST_REQUEST: if (i_ccu_done) state_q <= ST_FILL;
                default:    state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_REQUEST) && i_ccu_done) begin
            ccu_data_q <= i_ccu_data;
        end
    end

    assign o_ccu_en   = (state_q == ST_REQUEST);
    assign o_ccu_addr = {i_head_entry.addr, {OFFSET_W{1'b0}}};
    assign o_retire   = (state_q == ST_REQUEST) && i_ccu_done;
    assign o_fill_en  = (state_q == ST_FILL);
    assign o_dequeue  = (state_q == ST_FILL);

    // Stored bytes win over the line returned by the CCU
    always_comb begin
        o_fill.tag   = i_head;
        o_fill.dirty = i_head_entry.dirty;
        o_fill.addr  = i_head_entry.addr;
        for (int b = 0; b < LINE_BYTES; b++) begin
            o_fill.data[b*8 +: 8] = i_head_entry.byte_mask[b] ?
                                    i_head_entry.data[b*8 +: 8] : ccu_data_q[b*8 +: 8];
        end
    end

endmodule

/* mhq_lookup.sv */
// MHQ lookup stage: line match against entries and bypass, store byte placement, lu register
`timescale 1ns/100ps

module mhq_lookup
    import mhq_pkg::*;
(
    input  logic                       clk,
    input  logic                       i_reset,

    input  logic                       i_lookup_valid,
    input  logic                       i_lookup_dc_hit,
    input  logic [ADDR_W-1:0]          i_lookup_addr,
    input  lsu_func_t                  i_lookup_func,
    input  logic [DATA_W-1:0]          i_lookup_data,

    input  mhq_entry_t [MHQ_DEPTH-1:0] i_entries,
    input  mhq_tag_t                   i_tail,
    input  logic                       i_full,
    input  mhq_lu_t                    i_bypass,

    output mhq_lu_t                    o_lu
);

    mhq_addr_t  line_addr;
    offset_t    offset;
    logic       bypass_alloc;
    mhq_tag_t   alloc_tag;
    logic       full_eff;
    logic       match;
    mhq_tag_t   match_tag;
    byte_mask_t size_mask;

    assign line_addr = i_lookup_addr[ADDR_W-1:OFFSET_W];
    assign offset    = i_lookup_addr[OFFSET_W-1:0];

    // An allocation in flight in execute takes the current tail slot, so a new
    // allocation this cycle goes one slot further and may find the queue full
    assign bypass_alloc = i_bypass.en && !i_bypass.match;
    assign alloc_tag    = bypass_alloc ? mhq_tag_t'(i_tail + 1'b1) : i_tail;
    assign full_eff     = i_full || (bypass_alloc && i_entries[alloc_tag].valid);

    always_comb begin
        match     = 1'b0;
        match_tag = alloc_tag;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (i_entries[i].valid && !i_entries[i].retiring &&
                (i_entries[i].addr == line_addr)) begin
                match     = 1'b1;
                match_tag = mhq_tag_t'(i);
            end
        end
        // The line being allocated right now is not in the entry array yet
        if (bypass_alloc && (i_bypass.addr == line_addr)) begin
            match     = 1'b1;
            match_tag = i_bypass.tag;
        end
    end

    always_comb begin
        case (i_lookup_func)
            STORE_B: size_mask = byte_mask_t'(1);
            STORE_H: size_mask = byte_mask_t'(3);
            STORE_W: size_mask = byte_mask_t'(15);
            default: size_mask = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_lu <= '0;
        end else begin
            // Cache hits need no entry; a full queue only accepts merges
            o_lu.en        <= i_lookup_valid && !i_lookup_dc_hit && (match || !full_eff);
            o_lu.we        <= (i_lookup_func != LOAD);
            o_lu.match     <= match;
            o_lu.tag       <= match_tag;
            o_lu.addr      <= line_addr;
            o_lu.data      <= cacheline_t'(i_lookup_data) << {offset, 3'b000};
            o_lu.byte_mask <= size_mask << offset;
        end
    end

endmodule

/* mhq_pkg.sv */
// Sizes, line and entry types, stage records and the LSU function encoding for the MHQ
package mhq_pkg;

    // Queue geometry
    localparam int MHQ_DEPTH  = 4;
    localparam int MHQ_TAG_W  = 2;

    // Address and data widths
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_BYTES = 16;
    localparam int OFFSET_W   = 4;

    typedef logic [MHQ_TAG_W-1:0]         mhq_tag_t;
    typedef logic [ADDR_W-OFFSET_W-1:0]   mhq_addr_t;
    typedef logic [OFFSET_W-1:0]          offset_t;
    typedef logic [LINE_BYTES*8-1:0]      cacheline_t;
    typedef logic [LINE_BYTES-1:0]        byte_mask_t;

    // Stores write 1, 2 or 4 bytes taken from the low end of the store data
    typedef enum logic [1:0] {
        LOAD    = 2'b00,
        STORE_B = 2'b01,
        STORE_H = 2'b10,
        STORE_W = 2'b11
    } lsu_func_t;

    // One queue entry
    // The byte mask marks every byte that a store has written into the line
    typedef struct packed {
        logic       valid;
        logic       retiring;
        logic       dirty;
        mhq_addr_t  addr;
        cacheline_t data;
        byte_mask_t byte_mask;
    } mhq_entry_t;

    // Result of the lookup stage, applied by the execute stage one cycle later
    // Store bytes are already shifted to their position in the line
    typedef struct packed {
        logic       en;
        logic       we;
        logic       match;
        mhq_tag_t   tag;
        mhq_addr_t  addr;
        cacheline_t data;
        byte_mask_t byte_mask;
    } mhq_lu_t;

    // Merged line sent to the data cache
    typedef struct packed {
        mhq_tag_t   tag;
        logic       dirty;
        mhq_addr_t  addr;
        cacheline_t data;
    } mhq_fill_t;

endpackage

/* mhq_tb.sv */
// Directed testbench for the MHQ with clock, reset, CCU responder, line model, checks and watchdog
`timescale 1ns/100ps

module mhq_tb;
    import mhq_pkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int WAIT_LIMIT = 50;

    logic              clk;
    logic              i_reset;
    logic              i_lookup_valid;
    logic              i_lookup_dc_hit;
    logic [ADDR_W-1:0] i_lookup_addr;
    lsu_func_t         i_lookup_func;
    logic [DATA_W-1:0] i_lookup_data;
    mhq_tag_t          o_lookup_tag;
    logic              o_lookup_full;
    logic              o_fill_en;
    mhq_tag_t          o_fill_tag;
    logic              o_fill_dirty;
    logic [ADDR_W-1:0] o_fill_addr;
    cacheline_t        o_fill_data;
    logic              i_ccu_done;
    cacheline_t        i_ccu_data;
    logic              o_ccu_en;
    logic [ADDR_W-1:0] o_ccu_addr;

    logic [31:0] lcg_state = 32'h7d10_608f;
    int          errors;
    int          errors_at_test_start;
    int          tests_passed;
    int          tests_failed;
    int          ccu_requests;
    logic        ccu_en_prev;
    mhq_fill_t   fills [$];
    // Tag that the next allocation is expected to receive
    mhq_tag_t    exp_tail;

    // Bytes written by stores, per line address, until the line is filled
    byte_mask_t  model_mask [mhq_addr_t];
    cacheline_t  model_data [mhq_addr_t];

    mhq DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Outputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (o_ccu_en && !ccu_en_prev) begin
            ccu_requests = ccu_requests + 1;
        end
        ccu_en_prev = o_ccu_en;
        if (o_fill_en) begin
            fills.push_back(mhq_fill_t'({o_fill_tag, o_fill_dirty,
                                         o_fill_addr[ADDR_W-1:OFFSET_W], o_fill_data}));
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic cacheline_t random_line();
        cacheline_t line;
        for (int i = 0; i < LINE_BYTES / 4; i++) begin
            line[i*32 +: 32] = lcg_next();
        end
        return line;
    endfunction

    function automatic mhq_addr_t line_of(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:OFFSET_W];
    endfunction

    // A store writes 1, 2 or 4 low bytes of its data starting at the byte offset
    function automatic void model_store(input logic [ADDR_W-1:0] addr, input lsu_func_t func,
                                        input logic [DATA_W-1:0] data);
        mhq_addr_t  line;
        byte_mask_t mask;
        cacheline_t bytes;
        int         offset;
        int         size;
        line   = line_of(addr);
        offset = int'(addr[OFFSET_W-1:0]);
        size   = (func == STORE_W) ? 4 : ((func == STORE_H) ? 2 : 1);
        mask   = model_mask.exists(line) ? model_mask[line] : '0;
        bytes  = model_data.exists(line) ? model_data[line] : '0;
        for (int i = 0; i < size; i++) begin
            mask[offset + i]              = 1'b1;
            bytes[(offset + i)*8 +: 8]    = data[i*8 +: 8];
        end
        model_mask[line] = mask;
        model_data[line] = bytes;
    endfunction

    // Stored bytes replace CCU bytes, and any stored byte makes the line dirty
    function automatic mhq_fill_t expected_fill(input mhq_tag_t tag, input mhq_addr_t line,
                                                input cacheline_t ccu);
        byte_mask_t mask;
        cacheline_t bytes;
        mhq_fill_t  fill;
        mask       = model_mask.exists(line) ? model_mask[line] : '0;
        bytes      = model_data.exists(line) ? model_data[line] : '0;
        fill.tag   = tag;
        fill.dirty = |mask;
        fill.addr  = line;
        for (int b = 0; b < LINE_BYTES; b++) begin
            fill.data[b*8 +: 8] = mask[b] ? bytes[b*8 +: 8] : ccu[b*8 +: 8];
        end
        return fill;
    endfunction

    task automatic note_failure(input string msg);
        $display("Error: %s", msg);
        errors++;
    endtask

    task automatic compare_tag(input string name, input mhq_tag_t got, input mhq_tag_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_fill(input string name, input mhq_fill_t got, input mhq_fill_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_addr(input string name, input logic [ADDR_W-1:0] got,
                                input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // One lookup strobe; the registered tag is read one cycle later
    task automatic send_lookup(input logic [ADDR_W-1:0] addr, input lsu_func_t func,
                               input logic [DATA_W-1:0] data, input logic hit,
                               output mhq_tag_t tag);
        i_lookup_valid  = 1'b1;
        i_lookup_dc_hit = hit;
        i_lookup_addr   = addr;
        i_lookup_func   = func;
        i_lookup_data   = data;
        @(negedge clk);
        i_lookup_valid  = 1'b0;
        i_lookup_dc_hit = 1'b0;
        tag = o_lookup_tag;
    endtask

    task automatic send_store(input logic [ADDR_W-1:0] addr, input lsu_func_t func,
                              output mhq_tag_t tag);
        logic [DATA_W-1:0] data;
        data = lcg_next();
        send_lookup(addr, func, data, 1'b0, tag);
        model_store(addr, func, data);
    endtask

    // CCU side: wait for the request, check its line and answer a few cycles later
    task automatic answer_ccu(input mhq_addr_t line, output cacheline_t data);
        int waited;
        waited = 0;
        data   = random_line();
        while (!o_ccu_en && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_ccu_en) begin
            note_failure($sformatf("no CCU request arrived for line %h", line));
        end else begin
            compare_addr("o_ccu_addr", o_ccu_addr, {line, {OFFSET_W{1'b0}}});
            repeat (2) @(negedge clk);
            i_ccu_done = 1'b1;
            i_ccu_data = data;
            @(negedge clk);
            i_ccu_done = 1'b0;
        end
    endtask

    task automatic check_fill(input mhq_tag_t tag, input mhq_addr_t line, input cacheline_t ccu);
        int waited;
        waited = 0;
        while (fills.size() == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (fills.size() == 0) begin
            note_failure($sformatf("no fill arrived for line %h", line));
        end else begin
            compare_fill("o_fill", fills.pop_front(), expected_fill(tag, line, ccu));
        end
        model_mask.delete(line);
        model_data.delete(line);
        @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int exp_requests);
        repeat (8) @(negedge clk);
        @(posedge clk);
        if (ccu_requests != exp_requests) begin
            note_failure($sformatf("%0d CCU requests were made, %0d expected",
                                   ccu_requests, exp_requests));
        end
        if (fills.size() != 0) begin
            note_failure($sformatf("%0d unexpected fills were sent", fills.size()));
            fills.delete();
        end
        ccu_requests = 0;
        if (errors == errors_at_test_start) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_at_test_start);
        end
        errors_at_test_start = errors;
        @(negedge clk);
    endtask

    task automatic test_single_load();
        mhq_tag_t   tag;
        cacheline_t ccu;
        send_lookup(32'h0000_1234, LOAD, '0, 1'b0, tag);
        compare_tag("o_lookup_tag", tag, exp_tail);
        answer_ccu(line_of(32'h0000_1234), ccu);
        check_fill(exp_tail, line_of(32'h0000_1234), ccu);
        exp_tail++;
        finish_test("single load miss", 1);
    endtask

    task automatic test_bypass_merge();
        mhq_tag_t   tag_a;
        mhq_tag_t   tag_b;
        cacheline_t ccu;
        send_lookup(32'h0000_2200, LOAD, '0, 1'b0, tag_a);
        send_lookup(32'h0000_2208, LOAD, '0, 1'b0, tag_b);
        compare_tag("o_lookup_tag", tag_a, exp_tail);
        compare_tag("o_lookup_tag", tag_b, exp_tail);
        answer_ccu(line_of(32'h0000_2200), ccu);
        check_fill(exp_tail, line_of(32'h0000_2200), ccu);
        exp_tail++;
        finish_test("back to back loads to one line", 1);
    endtask

    task automatic test_store_merge();
        mhq_tag_t   tag;
        cacheline_t ccu;
        send_store(32'h0000_3304, STORE_W, tag);
        compare_tag("o_lookup_tag", tag, exp_tail);
        send_store(32'h0000_3300, STORE_B, tag);
        compare_tag("o_lookup_tag", tag, exp_tail);
        send_store(32'h0000_330a, STORE_H, tag);
        compare_tag("o_lookup_tag", tag, exp_tail);
        send_store(32'h0000_330c, STORE_W, tag);
        compare_tag("o_lookup_tag", tag, exp_tail);
        answer_ccu(line_of(32'h0000_3300), ccu);
        check_fill(exp_tail, line_of(32'h0000_3300), ccu);
        exp_tail++;
        finish_test("store merge", 1);
    endtask

    task automatic test_cache_hit();
        mhq_tag_t tag;
        send_lookup(32'h0000_4400, STORE_W, 32'hdead_beef, 1'b1, tag);
        finish_test("cache hit lookup", 0);
    endtask

    task automatic test_full_queue();
        mhq_tag_t   tag;
        cacheline_t ccu;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            send_lookup(32'h0000_5000 + 32'(i * LINE_BYTES), LOAD, '0, 1'b0, tag);
            compare_tag("o_lookup_tag", tag, mhq_tag_t'(exp_tail + i));
        end
        @(negedge clk);
        compare_flag("o_lookup_full", o_lookup_full, 1'b1);
        // A fifth distinct line has no free entry and is dropped
        send_lookup(32'h0000_5040, LOAD, '0, 1'b0, tag);
        send_store(32'h0000_5026, STORE_H, tag);
        compare_tag("o_lookup_tag", tag, mhq_tag_t'(exp_tail + 2));
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            answer_ccu(line_of(32'h0000_5000 + 32'(i * LINE_BYTES)), ccu);
            check_fill(mhq_tag_t'(exp_tail + i), line_of(32'h0000_5000 + 32'(i * LINE_BYTES)),
                       ccu);
        end
        // Four allocations bring the tail back to the same slot
        finish_test("full queue", MHQ_DEPTH);
    endtask

    task automatic test_refetch_after_done();
        mhq_tag_t   tag;
        cacheline_t ccu_a;
        cacheline_t ccu_b;
        send_lookup(32'h0000_6600, LOAD, '0, 1'b0, tag);
        compare_tag("o_lookup_tag", tag, exp_tail);
        answer_ccu(line_of(32'h0000_6600), ccu_a);
        // The head is retiring now, so the same line needs a new entry
        send_lookup(32'h0000_6604, LOAD, '0, 1'b0, tag);
        compare_tag("o_lookup_tag", tag, mhq_tag_t'(exp_tail + 1));
        check_fill(exp_tail, line_of(32'h0000_6600), ccu_a);
        answer_ccu(line_of(32'h0000_6600), ccu_b);
        check_fill(mhq_tag_t'(exp_tail + 1), line_of(32'h0000_6600), ccu_b);
        exp_tail = exp_tail + 2'd2;
        finish_test("lookup after CCU done", 2);
    endtask

    initial begin
        errors               = 0;
        errors_at_test_start = 0;
        tests_passed         = 0;
        tests_failed         = 0;
        ccu_requests         = 0;
        ccu_en_prev          = 1'b0;
        exp_tail             = '0;
        i_reset              = 1'b1;
        i_lookup_valid       = 1'b0;
        i_lookup_dc_hit      = 1'b0;
        i_lookup_addr        = '0;
        i_lookup_func        = LOAD;
        i_lookup_data        = '0;
        i_ccu_done           = 1'b0;
        i_ccu_data           = '0;
        repeat (10) @(negedge clk);
        i_reset = 1'b0;
        @(negedge clk);

        test_single_load();
        test_bypass_merge();
        test_store_merge();
        test_cache_hit();
        test_full_queue();
        test_refetch_after_done();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Each test needs far fewer than 200 cycles
    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", NUM_TESTS * 200);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the MHQ testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mhq_tb \
    -Mdir obj_dir -o mhq_sim -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/mhq_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
